// ==== checkpoint_alloc.sv ====
/*
 Checkpoint free pool. Checkpoint 0 is current after reset and all others are free.
 A checkpoint released while still current stays current until the next branch.
*/
`timescale 1ns/100ps
`default_nettype none

`include "checkpoint_config.svh"

module checkpoint_alloc (
	input  wire                                          clk,
	input  wire                                          rst,
	input  wire                                          dispatch,
	input  wire  [`CKPT_GROUP_SIZE-1:0]                  dispatch_branch,
	input  wire                                          group_full,
	input  wire                                          free,
	input  checkpoint_pkg::checkpt_ndx_t                 free_chkpt,
	output checkpoint_pkg::checkpt_ndx_t                 cur_chkpt,
	output logic [$clog2(`CKPT_CHECKPOINTS+1)-1:0]       free_count,
	output logic                                         dispatch_stall
);

	// One bit per checkpoint, set while the checkpoint is in the pool
	logic [`CKPT_CHECKPOINTS-1:0] free_map;
	logic ckpt_avail;
	logic need_ckpt;
	logic take;
	checkpoint_pkg::checkpt_ndx_t low_free;

	// ==================================================
	// Pool status
	// ==================================================

	assign ckpt_avail = |free_map;
	assign need_ckpt = |dispatch_branch;

	// Stall on a full tail group, or on a branch group with nothing to give it
	assign dispatch_stall = group_full || (need_ckpt && !ckpt_avail);
	assign take = dispatch && !dispatch_stall && need_ckpt;

	// Lowest free checkpoint, the descending scan leaves the smallest index
	always_comb begin
		low_free = '0;
		for (int c = `CKPT_CHECKPOINTS - 1; c >= 0; c--) begin
			if (free_map[c])
				low_free = checkpt_ndx_t_cast(c);
		end
	end

	// Population count of the pool
	always_comb begin
		free_count = '0;
		for (int c = 0; c < `CKPT_CHECKPOINTS; c++)
			free_count = free_count + free_map[c];
	end

	function automatic checkpoint_pkg::checkpt_ndx_t checkpt_ndx_t_cast(input int c);
		checkpt_ndx_t_cast = c[$bits(checkpoint_pkg::checkpt_ndx_t)-1:0];
	endfunction

	// ==================================================
	// Allocation and release
	// ==================================================

	// The freer never releases the index being taken, since that one is
	// still in the pool, so clear then set cannot collide
	always_ff @(posedge clk) begin
		if (rst) begin
			free_map <= {{(`CKPT_CHECKPOINTS-1){1'b1}}, 1'b0};
			cur_chkpt <= '0;
		end else begin
			if (take) begin
				free_map[low_free] <= 1'b0;
				cur_chkpt <= low_free;
			end
			if (free)
				free_map[free_chkpt] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== checkpoint_config.svh ====
/*
 Sizes of the checkpoint slice. CKPT_GROUPS must equal ROB entries divided by group size
 and must be a power of two. Checkpoint count must be at least two.
*/
`ifndef CHECKPOINT_CONFIG_SVH
`define CHECKPOINT_CONFIG_SVH

// ==================================================
// ROB geometry
// ==================================================

// Total number of reorder buffer entries
`define CKPT_ROB_ENTRIES 16

// Instructions dispatched together as one group
`define CKPT_GROUP_SIZE 4

// Number of dispatch groups held by the ROB
`define CKPT_GROUPS 4

// ==================================================
// Register map checkpoints
// ==================================================

// Checkpoint 0 is the current map after reset and is not in the free pool
`define CKPT_CHECKPOINTS 4

`endif

// ==== checkpoint_freer.sv ====
/*
 Registered scan for finished branch groups, one release per cycle, lowest group first.
 The released checkpoint is the one recorded by the following group.
*/
`timescale 1ns/100ps
`default_nettype none

`include "checkpoint_config.svh"

module checkpoint_freer (
	input  wire                                                  clk,
	input  wire                                                  rst,
	input  checkpoint_pkg::rob_state_e [`CKPT_ROB_ENTRIES-1:0]   entry_state,
	input  wire  [`CKPT_ROB_ENTRIES-1:0]                         entry_branch,
	input  checkpoint_pkg::checkpt_ndx_t [`CKPT_ROB_ENTRIES-1:0] entry_cndx,
	input  wire  [`CKPT_GROUPS-1:0]                              group_freed,
	output logic                                                 free,
	output checkpoint_pkg::checkpt_ndx_t                         free_chkpt,
	output checkpoint_pkg::group_ndx_t                           free_group
);

	logic [`CKPT_GROUPS-1:0] qual;
	logic pick_valid;
	checkpoint_pkg::group_ndx_t pick_group;
	checkpoint_pkg::group_ndx_t pick_next;

	// ==================================================
	// Per-group conditions
	// ==================================================

	// All branches of a group have resolved once every entry is DONE or EMPTY
	always_comb begin
		logic all_done;
		logic any_branch;
		logic next_busy;
		logic pulsed;
		checkpoint_pkg::group_ndx_t nxt;
		qual = '0;
		for (int g = 0; g < `CKPT_GROUPS; g++) begin
			all_done = 1'b1;
			any_branch = 1'b0;
			next_busy = 1'b0;
			nxt = checkpoint_pkg::group_ndx_t'(g + 1);
			for (int e = 0; e < `CKPT_GROUP_SIZE; e++) begin
				if (entry_state[g * `CKPT_GROUP_SIZE + e] == checkpoint_pkg::ISSUED)
					all_done = 1'b0;
				if (entry_branch[g * `CKPT_GROUP_SIZE + e])
					any_branch = 1'b1;
				// An empty successor holds a stale checkpoint index
				if (entry_state[int'(nxt) * `CKPT_GROUP_SIZE + e] != checkpoint_pkg::EMPTY)
					next_busy = 1'b1;
			end
			// The flag set by last cycle's pulse is not visible yet
			pulsed = free && (int'(free_group) == g);
			qual[g] = !group_freed[g] && !pulsed && all_done && any_branch && next_busy;
		end
	end

	// ==================================================
	// Selection
	// ==================================================

	assign pick_valid = |qual;

	// Descending scan so the lowest qualifying group ends up selected
	always_comb begin
		pick_group = '0;
		for (int g = `CKPT_GROUPS - 1; g >= 0; g--) begin
			if (qual[g])
				pick_group = checkpoint_pkg::group_ndx_t'(g);
		end
	end

	assign pick_next = pick_group + 1'b1;

	always_ff @(posedge clk) begin
		if (rst)
			free <= 1'b0;
		else
			free <= pick_valid;
	end

	// All entries of a group hold the same index, so entry 0 stands for it
	always_ff @(posedge clk) begin
		free_group <= pick_group;
		free_chkpt <= entry_cndx[int'(pick_next) * `CKPT_GROUP_SIZE];
	end

endmodule

`default_nettype wire

// ==== checkpoint_input.txt ====
// Word digits: cmd a b c. 0 idle a cycles, 1 dispatch valid a branch b stall c, 2 complete a
// 3 commit, 4 free with chkpt a group b, 5 free_count a, 6 no free for a cycles, 7 dispatch + complete c
5300 // reset state
6200
1110 // g0 branch takes ckpt 1
1300 // g1 records ckpt 1
5200
2000 // g0 finished
4100
0100
5300
6400
1320 // g2 branch takes ckpt 1
1110 // g3 branch takes ckpt 2
2400
2500 // g1 done without a branch
6300
2800 // g2 still has entry 9 issued
6300
3000 // retire g0
2c00 // g3 done with an empty successor
6300
7319 // g0 filled and g2 done in one cycle
4120
4230
0100
5200
3000 // retire g1
1110
3000
1110
3000
5000
1111 // no checkpoint left
5000
2000
2100
4300
0100
5100
1110 // accepted after the free
6400

// ==== checkpoint_pkg.sv ====
/*
 Index types and entry states shared by the checkpoint slice.
 Widths follow the macros in the config header.
*/
`default_nettype none

`include "checkpoint_config.svh"

package checkpoint_pkg;

	// ==================================================
	// Index types
	// ==================================================

	// Selects one ROB entry
	typedef logic [$clog2(`CKPT_ROB_ENTRIES)-1:0] rob_ndx_t;

	// Selects one dispatch group, wraps naturally at the group count
	typedef logic [$clog2(`CKPT_GROUPS)-1:0] group_ndx_t;

	// Selects one register map checkpoint
	typedef logic [$clog2(`CKPT_CHECKPOINTS)-1:0] checkpt_ndx_t;

	// ==================================================
	// Entry state
	// ==================================================

	// EMPTY covers both never-written slots and invalid slots of a group
	// ISSUED entries are waiting on completion
	// DONE entries have finished and wait for commit
	typedef enum logic [1:0] {
		EMPTY  = 2'd0,
		ISSUED = 2'd1,
		DONE   = 2'd2
	} rob_state_e;

endpackage

`default_nettype wire

// ==== checkpoint_unit.sv ====
/*
 Top of the checkpoint slice. A dispatch while dispatch_stall is high is dropped.
 complete_ndx must point at an issued entry for the strobe to have effect.
*/
`timescale 1ns/100ps
`default_nettype none

`include "checkpoint_config.svh"

module checkpoint_unit (
	input  wire                                    clk,
	input  wire                                    rst,
	input  wire                                    dispatch,
	input  wire  [`CKPT_GROUP_SIZE-1:0]            dispatch_valid,
	input  wire  [`CKPT_GROUP_SIZE-1:0]            dispatch_branch,
	input  wire                                    complete,
	input  checkpoint_pkg::rob_ndx_t               complete_ndx,
	input  wire                                    commit,
	output logic                                   dispatch_stall,
	output checkpoint_pkg::group_ndx_t             dispatch_group,
	output logic                                   free,
	output checkpoint_pkg::checkpt_ndx_t           free_chkpt,
	output checkpoint_pkg::group_ndx_t             free_group,
	output logic [$clog2(`CKPT_CHECKPOINTS+1)-1:0] free_count
);

	// ==================================================
	// Internal nets
	// ==================================================

	checkpoint_pkg::rob_state_e [`CKPT_ROB_ENTRIES-1:0]   entry_state;
	logic [`CKPT_ROB_ENTRIES-1:0]                         entry_branch;
	checkpoint_pkg::checkpt_ndx_t [`CKPT_ROB_ENTRIES-1:0] entry_cndx;
	logic [`CKPT_GROUPS-1:0]                              group_freed;
	checkpoint_pkg::checkpt_ndx_t                         cur_chkpt;
	logic                                                 group_full;
	logic                                                 dispatch_ok;

	// The array sees only accepted dispatches
	assign dispatch_ok = dispatch && !dispatch_stall;

	rob_status_array rob_status_array_i (
		.clk             (clk),
		.rst             (rst),
		.dispatch        (dispatch_ok),
		.dispatch_valid  (dispatch_valid),
		.dispatch_branch (dispatch_branch),
		.cur_chkpt       (cur_chkpt),
		.complete        (complete),
		.complete_ndx    (complete_ndx),
		.commit          (commit),
		.free            (free),
		.free_group      (free_group),
		.entry_state     (entry_state),
		.entry_branch    (entry_branch),
		.entry_cndx      (entry_cndx),
		.group_freed     (group_freed),
		.dispatch_group  (dispatch_group),
		.group_full      (group_full)
	);

	checkpoint_alloc checkpoint_alloc_i (
		.clk             (clk),
		.rst             (rst),
		.dispatch        (dispatch),
		.dispatch_branch (dispatch_branch),
		.group_full      (group_full),
		.free            (free),
		.free_chkpt      (free_chkpt),
		.cur_chkpt       (cur_chkpt),
		.free_count      (free_count),
		.dispatch_stall  (dispatch_stall)
	);

	checkpoint_freer checkpoint_freer_i (
		.clk          (clk),
		.rst          (rst),
		.entry_state  (entry_state),
		.entry_branch (entry_branch),
		.entry_cndx   (entry_cndx),
		.group_freed  (group_freed),
		.free         (free),
		.free_chkpt   (free_chkpt),
		.free_group   (free_group)
	);

endmodule

`default_nettype wire

// ==== rob_status_array.sv ====
/*
 ROB status storage, written one group at a time at the tail and retired at the head.
 The dispatch input must already be qualified by the stall. Commit assumes the head is done.
*/
`timescale 1ns/100ps
`default_nettype none

`include "checkpoint_config.svh"

module rob_status_array (
	input  wire                                              clk,
	input  wire                                              rst,
	input  wire                                              dispatch,
	input  wire  [`CKPT_GROUP_SIZE-1:0]                      dispatch_valid,
	input  wire  [`CKPT_GROUP_SIZE-1:0]                      dispatch_branch,
	input  checkpoint_pkg::checkpt_ndx_t                     cur_chkpt,
	input  wire                                              complete,
	input  checkpoint_pkg::rob_ndx_t                         complete_ndx,
	input  wire                                              commit,
	input  wire                                              free,
	input  checkpoint_pkg::group_ndx_t                       free_group,
	output checkpoint_pkg::rob_state_e [`CKPT_ROB_ENTRIES-1:0]   entry_state,
	output logic [`CKPT_ROB_ENTRIES-1:0]                     entry_branch,
	output checkpoint_pkg::checkpt_ndx_t [`CKPT_ROB_ENTRIES-1:0] entry_cndx,
	output logic [`CKPT_GROUPS-1:0]                          group_freed,
	output checkpoint_pkg::group_ndx_t                       dispatch_group,
	output logic                                             group_full
);

	// Oldest group still in flight
	checkpoint_pkg::group_ndx_t head_group;
	logic head_busy;
	logic head_occupied;

	// ==================================================
	// Occupancy
	// ==================================================

	// A group counts as occupied while any of its entries is not EMPTY
	always_comb begin
		group_full = 1'b0;
		head_occupied = 1'b0;
		for (int e = 0; e < `CKPT_GROUP_SIZE; e++) begin
			if (entry_state[int'(dispatch_group) * `CKPT_GROUP_SIZE + e] != checkpoint_pkg::EMPTY)
				group_full = 1'b1;
			if (entry_state[int'(head_group) * `CKPT_GROUP_SIZE + e] != checkpoint_pkg::EMPTY)
				head_occupied = 1'b1;
		end
	end

	// Head and tail differ whenever some dispatched group is still in flight,
	// even one that carried no valid instruction
	assign head_busy = (head_group != dispatch_group) || head_occupied;

	// ==================================================
	// Entry state and pointers
	// ==================================================

	// Updates are applied in the order complete, free, commit, dispatch so the
	// youngest event wins when two touch the same entry or flag
	always_ff @(posedge clk) begin
		if (rst) begin
			entry_state <= '{default: checkpoint_pkg::EMPTY};
			entry_branch <= '0;
			group_freed <= '0;
			head_group <= '0;
			dispatch_group <= '0;
		end else begin
			// Only an issued entry can finish
			if (complete && entry_state[complete_ndx] == checkpoint_pkg::ISSUED)
				entry_state[complete_ndx] <= checkpoint_pkg::DONE;

			if (free)
				group_freed[free_group] <= 1'b1;

			// Retire the head group and make its slot reusable
			if (commit && head_busy) begin
				for (int e = 0; e < `CKPT_GROUP_SIZE; e++) begin
					entry_state[int'(head_group) * `CKPT_GROUP_SIZE + e] <= checkpoint_pkg::EMPTY;
					entry_branch[int'(head_group) * `CKPT_GROUP_SIZE + e] <= 1'b0;
				end
				group_freed[head_group] <= 1'b0;
				head_group <= head_group + 1'b1;
			end

			// Invalid slots of a group go straight to EMPTY
			if (dispatch) begin
				for (int e = 0; e < `CKPT_GROUP_SIZE; e++) begin
					entry_state[int'(dispatch_group) * `CKPT_GROUP_SIZE + e] <=
						dispatch_valid[e] ? checkpoint_pkg::ISSUED : checkpoint_pkg::EMPTY;
					entry_branch[int'(dispatch_group) * `CKPT_GROUP_SIZE + e] <= dispatch_branch[e];
				end
				dispatch_group <= dispatch_group + 1'b1;
			end
		end
	end

	// Every entry of a group records the checkpoint current before the group
	// took its own, so the following group points at the branch's checkpoint
	always_ff @(posedge clk) begin
		if (dispatch) begin
			for (int e = 0; e < `CKPT_GROUP_SIZE; e++)
				entry_cndx[int'(dispatch_group) * `CKPT_GROUP_SIZE + e] <= cur_chkpt;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_checkpoint_unit -f sim.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log || { echo "run failed, see sim.log"; exit 1; }
echo "run passed"

// ==== sim.f ====
+incdir+.
checkpoint_pkg.sv
rob_status_array.sv
checkpoint_alloc.sv
checkpoint_freer.sv
checkpoint_unit.sv
tb_checkpoint_unit.sv

// ==== tb_checkpoint_unit.sv ====
/*
 Self-checking testbench driven by checkpoint_input.txt, run from the project root.
 Stops at the first mismatch. Every free pulse must be claimed by an expect line.
*/
`timescale 1ns/100ps
`default_nettype none

`include "checkpoint_config.svh"

module tb_checkpoint_unit;

	localparam int MAX_CMDS = 64;
	localparam int RESET_CYCLES = 8;
	localparam int PULSE_WAIT = 16;
	// Longest command is a pulse wait, rounded up
	localparam int CYCLES_PER_CMD = 20;
	localparam int COUNT_W = $clog2(`CKPT_CHECKPOINTS + 1);

	typedef logic [COUNT_W-1:0] count_t;

	logic clk = 1'b0;
	logic rst;
	logic dispatch;
	logic [`CKPT_GROUP_SIZE-1:0] dispatch_valid;
	logic [`CKPT_GROUP_SIZE-1:0] dispatch_branch;
	logic complete;
	checkpoint_pkg::rob_ndx_t complete_ndx;
	logic commit;
	logic dispatch_stall;
	checkpoint_pkg::group_ndx_t dispatch_group;
	logic free;
	checkpoint_pkg::checkpt_ndx_t free_chkpt;
	checkpoint_pkg::group_ndx_t free_group;
	count_t free_count;

	// Command words, hex digits are cmd, a, b, c from the top
	logic [15:0] cmds [0:MAX_CMDS-1];
	int n_cmds = 0;
	logic loaded = 1'b0;

	// Free pulses seen but not yet claimed by an expect line
	checkpoint_pkg::checkpt_ndx_t seen_chkpt [$];
	checkpoint_pkg::group_ndx_t seen_group [$];

	// Tail group as the testbench predicts it, advanced on every accepted dispatch
	checkpoint_pkg::group_ndx_t tail_model;

	checkpoint_unit checkpoint_unit_i (
		.clk             (clk),
		.rst             (rst),
		.dispatch        (dispatch),
		.dispatch_valid  (dispatch_valid),
		.dispatch_branch (dispatch_branch),
		.complete        (complete),
		.complete_ndx    (complete_ndx),
		.commit          (commit),
		.dispatch_stall  (dispatch_stall),
		.dispatch_group  (dispatch_group),
		.free            (free),
		.free_chkpt      (free_chkpt),
		.free_group      (free_group),
		.free_count      (free_count)
	);

	always #4 clk = ~clk;

	// ==================================================
	// Reporting and checks
	// ==================================================

	task automatic fail_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopping on the first failure");
	endtask

	task automatic report_mismatch(input string name, input int got, input int exp);
		$display("error: time %0t, signal %s, got %0d, expected %0d", $time, name, got, exp);
		fail_run();
	endtask

	task automatic check_chkpt(input string name, input checkpoint_pkg::checkpt_ndx_t got,
			input checkpoint_pkg::checkpt_ndx_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_group(input string name, input checkpoint_pkg::group_ndx_t got,
			input checkpoint_pkg::group_ndx_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, int'(got), int'(exp));
	endtask

	// ==================================================
	// Command tasks
	// ==================================================

	// One clock, strobes drop on the falling edge and a showing pulse is queued
	task automatic step();
		@(negedge clk);
		dispatch = 1'b0;
		complete = 1'b0;
		commit = 1'b0;
		dispatch_valid = '0;
		dispatch_branch = '0;
		if (free === 1'b1) begin
			seen_chkpt.push_back(free_chkpt);
			seen_group.push_back(free_group);
		end
	endtask

	// A stalled dispatch must leave the tail group where it was
	task automatic do_dispatch(input logic [`CKPT_GROUP_SIZE-1:0] valid,
			input logic [`CKPT_GROUP_SIZE-1:0] branch, input logic stall_exp,
			input logic with_complete, input checkpoint_pkg::rob_ndx_t ndx);
		dispatch = 1'b1;
		dispatch_valid = valid;
		dispatch_branch = branch;
		complete = with_complete;
		complete_ndx = ndx;
		#1;
		check_level("dispatch_stall", dispatch_stall, stall_exp);
		if (!stall_exp)
			tail_model = checkpoint_pkg::group_ndx_t'(tail_model + 1);
		step();
		check_group("dispatch_group", dispatch_group, tail_model);
	endtask

	task automatic expect_free(input checkpoint_pkg::checkpt_ndx_t chkpt_exp,
			input checkpoint_pkg::group_ndx_t group_exp);
		int waited;
		waited = 0;
		while (seen_group.size() == 0 && waited < PULSE_WAIT) begin
			step();
			waited++;
		end
		if (seen_group.size() == 0) begin
			$display("no free pulse for group %0d arrived within %0d cycles",
				group_exp, PULSE_WAIT);
			fail_run();
		end else begin
			check_group("free_group", seen_group.pop_front(), group_exp);
			check_chkpt("free_chkpt", seen_chkpt.pop_front(), chkpt_exp);
		end
	endtask

	// Nothing may be released while the ROB state does not meet the rule
	task automatic expect_quiet(input int cycles);
		repeat (cycles) step();
		if (seen_group.size() != 0) begin
			$display("unexpected free pulse for group %0d with checkpoint %0d",
				seen_group[0], seen_chkpt[0]);
			fail_run();
		end
	endtask

	// ==================================================
	// Watchdog
	// ==================================================

	initial begin
		wait (loaded);
		#((RESET_CYCLES + n_cmds * CYCLES_PER_CMD) * 8);
		$display("timeout: the command list did not finish in the expected time");
		fail_run();
	end

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		logic [15:0] w;
		rst = 1'b1;
		dispatch = 1'b0;
		dispatch_valid = '0;
		dispatch_branch = '0;
		complete = 1'b0;
		complete_ndx = '0;
		commit = 1'b0;
		tail_model = '0;
		for (int i = 0; i < MAX_CMDS; i++)
			cmds[i] = 16'hffff;
		$readmemh("checkpoint_input.txt", cmds);
		while (n_cmds < MAX_CMDS && cmds[n_cmds] !== 16'hffff)
			n_cmds++;
		if (n_cmds == 0) begin
			$display("no commands were read from checkpoint_input.txt");
			fail_run();
		end
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < n_cmds; i++) begin
			w = cmds[i];
			case (w[15:12])
				4'h0: repeat (int'(w[11:8])) step();
				4'h1: do_dispatch(w[11:8], w[7:4], w[0], 1'b0, '0);
				4'h2: begin
					complete = 1'b1;
					complete_ndx = checkpoint_pkg::rob_ndx_t'(w[11:8]);
					step();
				end
				4'h3: begin
					commit = 1'b1;
					step();
				end
				4'h4: expect_free(checkpoint_pkg::checkpt_ndx_t'(w[11:8]),
					checkpoint_pkg::group_ndx_t'(w[7:4]));
				4'h5: check_count("free_count", free_count, count_t'(w[11:8]));
				4'h6: expect_quiet(int'(w[11:8]));
				4'h7: do_dispatch(w[11:8], w[7:4], 1'b0, 1'b1,
					checkpoint_pkg::rob_ndx_t'(w[3:0]));
				default: begin
					$display("unknown command word %h at line %0d of the command list", w, i);
					fail_run();
				end
			endcase
		end
		if (seen_group.size() != 0) begin
			$display("free pulse for group %0d was never expected", seen_group[0]);
			fail_run();
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
